/* Makefile */
TOP = character_generator_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f character_generator.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f character_generator.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* character_generator.f */
logic/glyph_pkg.sv
logic/glyph_picker.sv
logic/stroke_rom.sv
logic/stroke_sequencer.sv
logic/round_control.sv
logic/character_generator.sv
tests/character_generator_tb.sv

/* logic/character_generator.sv */
`timescale 1ns/100ps

module character_generator
   import glyph_pkg::*;
(
   input  logic    clock,
   input  logic    reset,
   input  round_t  current_round,
   input  logic    stroke_request,
   output square_t source_square,
   output square_t dest_square,
   output logic    stroke_valid,
   output glyph_t  glyph_index,
   output letter_t letter,
   output logic    round_done,
   output logic    first_part_done
);

   logic          draw;
   logic          glyph_done;
   logic          pick;
   glyph_t        glyph;
   stroke_count_t stroke_index;
   stroke_count_t stroke_total;
   square_t       rom_source;
   square_t       rom_dest;

   assign glyph_index = glyph;

   round_control u_round_control (
      .clock           (clock),
      .reset           (reset),
      .current_round   (current_round),
      .glyph_done      (glyph_done),
      .draw            (draw),
      .round_done      (round_done),
      .first_part_done (first_part_done)
   );

   glyph_picker u_glyph_picker (
      .clock (clock),
      .reset (reset),
      .pick  (pick),
      .glyph (glyph)
   );

   stroke_sequencer u_stroke_sequencer (
      .clock          (clock),
      .reset          (reset),
      .draw           (draw),
      .stroke_request (stroke_request),
      .pick           (pick),
      .glyph          (glyph),
      .stroke_index   (stroke_index),
      .source         (rom_source),
      .dest           (rom_dest),
      .stroke_total   (stroke_total),
      .source_square  (source_square),
      .dest_square    (dest_square),
      .stroke_valid   (stroke_valid),
      .glyph_done     (glyph_done)
   );

   // Table lookup for the sequencer, letter goes straight out
   stroke_rom u_stroke_rom (
      .glyph        (glyph),
      .stroke_index (stroke_index),
      .source       (rom_source),
      .dest         (rom_dest),
      .stroke_total (stroke_total),
      .letter       (letter)
   );

endmodule

/* logic/glyph_picker.sv */
`timescale 1ns/100ps

module glyph_picker
   import glyph_pkg::*;
(
   input  logic   clock,
   input  logic   reset,
   input  logic   pick,
   output glyph_t glyph
);

   glyph_t lfsr;
   glyph_t lfsr_next;
   logic   feedback;

   // XNOR taps on bits 3 and 2, all ones is the lockup state
   assign feedback  = ~(lfsr[3] ^ lfsr[2]);
   assign lfsr_next = {lfsr[2:0], feedback};

   // One step per pick, so each round draws the next state
   always_ff @(posedge clock) begin
      if (reset) begin
         lfsr  <= LFSR_SEED;
         glyph <= '0;
      end else if (pick) begin
         lfsr  <= lfsr_next;
         glyph <= lfsr_next;   // Held until the next pick
      end
   end

endmodule

/* logic/glyph_pkg.sv */
package glyph_pkg;

   ////////////////////
   // Field widths
   ////////////////////

   typedef logic [3:0] square_t;        // Grid square 0-8, or idle marker
   typedef logic [3:0] glyph_t;         // Index into the letter table
   typedef logic [3:0] stroke_count_t;
   typedef logic [2:0] round_t;
   typedef logic [7:0] letter_t;        // ASCII
   typedef logic [7:0] hold_count_t;

   ////////////////////
   // Constants
   ////////////////////

   localparam int GLYPH_COUNT = 16;

   localparam square_t       IDLE_SQUARE = 4'd9;   // Shown when no stroke is out
   localparam stroke_count_t MAX_STROKES = 4'd9;   // Longest list, Q
   localparam glyph_t        LFSR_SEED   = 4'd8;
   localparam round_t        MAX_ROUND   = 3'd6;

   // Round-done hold, in clock cycles
   localparam hold_count_t HOLD_CYCLES = 8'd20;

   ////////////////////
   // FSM encodings
   ////////////////////

   typedef enum logic [1:0] {
      ROUND_IDLE,
      ROUND_DRAWING,
      ROUND_FINISHED
   } round_state_t;

   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_RETRIEVE,   // Glyph is picked here
      SEQ_SUPPLY
   } seq_state_t;

endpackage

/* logic/round_control.sv */
`timescale 1ns/100ps

module round_control
   import glyph_pkg::*;
(
   input  logic   clock,
   input  logic   reset,
   input  round_t current_round,
   input  logic   glyph_done,
   output logic   draw,
   output logic   round_done,
   output logic   first_part_done
);

   round_state_t state;
   round_state_t next_state;
   hold_count_t  hold_count;
   logic         last_round;
   logic         hold_over;

   assign last_round = current_round == MAX_ROUND;
   assign hold_over  = hold_count == HOLD_CYCLES - 1'b1;

   always_comb begin
      next_state = state;
      case (state)
         ROUND_IDLE:     if (!last_round) next_state = ROUND_DRAWING;
         ROUND_DRAWING:  if (glyph_done) next_state = ROUND_FINISHED;
         ROUND_FINISHED: if (hold_over) next_state = ROUND_IDLE;
         default:        next_state = ROUND_IDLE;
      endcase
   end

   always_ff @(posedge clock) begin
      if (reset)
         state <= ROUND_IDLE;
      else
         state <= next_state;
   end

   ////////////////////
   // Done-hold timer
   ////////////////////

   // Runs only while finished, cleared otherwise
   always_ff @(posedge clock) begin
      if (reset || state != ROUND_FINISHED)
         hold_count <= '0;
      else
         hold_count <= hold_count + 1'b1;
   end

   assign draw       = state == ROUND_DRAWING;
   assign round_done = state == ROUND_FINISHED;

   // Play has stopped at the last round
   assign first_part_done = (state == ROUND_IDLE) && last_round && !reset;

endmodule

/* logic/stroke_rom.sv */
`timescale 1ns/100ps

module stroke_rom
   import glyph_pkg::*;
(
   input  glyph_t        glyph,
   input  stroke_count_t stroke_index,
   output square_t       source,
   output square_t       dest,
   output stroke_count_t stroke_total,
   output letter_t       letter
);

   // Grid squares
   //    0 1 2
   //    3 4 5
   //    6 7 8

   ////////////////////
   // Stroke tables
   ////////////////////

   // Start square of each stroke, rows in glyph order
   localparam square_t SOURCE_TABLE [GLYPH_COUNT][MAX_STROKES] = '{
      '{1, 3, 1, 5, 3, 4, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // A
      '{2, 1, 0, 3, 6, 7, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // C
      '{0, 3, 0, 1, 2, 5, 8, 7, IDLE_SQUARE},                       // D
      '{0, 3, 0, 1, 3, 4, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // F
      '{0, 1, 1, 4, 6, 7, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // I
      '{0, 1, 1, 4, 7, 6, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // J
      '{0, 3, 1, 3, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},
      '{0, 3, 6, 7, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},
      '{0, 3, 0, 2, 2, 5, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // M
      '{0, 3, 0, 4, 8, 5, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // N
      '{2, 1, 0, 3, 6, 7, 8, 5, 4},                                 // Q, tail last
      '{0, 3, 0, 1, 2, 5, 4, 3, IDLE_SQUARE},                       // R
      '{2, 1, 0, 3, 4, 5, 8, 7, IDLE_SQUARE},                       // S
      '{0, 1, 1, 4, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},
      '{0, 3, 6, 1, 8, 5, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // W
      '{0, 4, 2, 4, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE}
   };

   // End square of each stroke
   localparam square_t DEST_TABLE [GLYPH_COUNT][MAX_STROKES] = '{
      '{3, 6, 5, 8, 4, 5, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // A
      '{1, 0, 3, 6, 7, 8, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // C
      '{3, 6, 1, 2, 5, 8, 7, 6, IDLE_SQUARE},                       // D
      '{3, 6, 1, 2, 4, 5, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // F
      '{1, 2, 4, 7, 7, 8, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // I
      '{1, 2, 4, 7, 6, 3, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // J
      '{3, 6, 3, 7, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},
      '{3, 6, 7, 8, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},
      '{3, 6, 7, 7, 5, 8, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // M
      '{3, 6, 4, 8, 5, 2, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // N
      '{1, 0, 3, 6, 7, 8, 5, 2, 8},                                 // Q
      '{3, 6, 1, 2, 5, 4, 3, 8, IDLE_SQUARE},                       // R
      '{1, 0, 3, 4, 5, 8, 7, 6, IDLE_SQUARE},                       // S
      '{1, 2, 4, 7, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},
      '{3, 6, 1, 8, 5, 2, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE},   // W
      '{4, 8, 4, 6, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE, IDLE_SQUARE}
   };

   ////////////////////
   // Per glyph data
   ////////////////////

   localparam stroke_count_t COUNT_TABLE [GLYPH_COUNT] = '{
      6, 6, 8, 6, 6, 6, 4, 4, 6, 6, 9, 8, 8, 4, 6, 4
   };

   localparam letter_t LETTER_TABLE [GLYPH_COUNT] = '{
      "A", "C", "D", "F", "I", "J", "K", "L",
      "M", "N", "Q", "R", "S", "T", "W", "X"
   };

   assign stroke_total = COUNT_TABLE[glyph];
   assign letter       = LETTER_TABLE[glyph];

   // Past the end of the list only the idle marker comes out
   always_comb begin
      if (stroke_index < stroke_total) begin
         source = SOURCE_TABLE[glyph][stroke_index];
         dest   = DEST_TABLE[glyph][stroke_index];
      end else begin
         source = IDLE_SQUARE;
         dest   = IDLE_SQUARE;
      end
   end

endmodule

/* logic/stroke_sequencer.sv */
`timescale 1ns/100ps

module stroke_sequencer
   import glyph_pkg::*;
(
   input  logic          clock,
   input  logic          reset,
   input  logic          draw,
   input  logic          stroke_request,
   output logic          pick,
   input  glyph_t        glyph,
   output stroke_count_t stroke_index,
   input  square_t       source,
   input  square_t       dest,
   input  stroke_count_t stroke_total,
   output square_t       source_square,
   output square_t       dest_square,
   output logic          stroke_valid,
   output logic          glyph_done
);

   seq_state_t    state;
   stroke_count_t stroke_count;   // Strokes handed out so far
   logic          strokes_left;
   logic          serve;

   assign stroke_index = stroke_count;

   assign pick         = state == SEQ_RETRIEVE;   // Glyph settles on leaving retrieve
   assign strokes_left = stroke_count < stroke_total;
   assign serve        = (state == SEQ_SUPPLY) && draw && stroke_request && strokes_left;

   assign glyph_done   = (stroke_count == stroke_total) && (stroke_count != '0);

   ////////////////////
   // Supply FSM
   ////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         state         <= SEQ_IDLE;
         stroke_count  <= '0;
         source_square <= IDLE_SQUARE;
         dest_square   <= IDLE_SQUARE;
         stroke_valid  <= 1'b0;
      end else begin
         stroke_valid <= serve;   // One pulse per stroke served

         case (state)
            SEQ_IDLE: begin
               stroke_count <= '0;
               if (draw)
                  state <= SEQ_RETRIEVE;
            end

            SEQ_RETRIEVE: begin
               stroke_count <= '0;
               state        <= SEQ_SUPPLY;
            end

            SEQ_SUPPLY: begin
               if (!draw) begin
                  state         <= SEQ_IDLE;
                  stroke_count  <= '0;
                  source_square <= IDLE_SQUARE;
                  dest_square   <= IDLE_SQUARE;
               end else if (serve) begin
                  source_square <= source;
                  dest_square   <= dest;
                  stroke_count  <= stroke_count + 1'b1;
               end
            end

            default: state <= SEQ_IDLE;
         endcase
      end
   end

endmodule

/* tests/character_generator_tb.sv */
`timescale 1ns/100ps

module character_generator_tb
   import glyph_pkg::*;
();

   localparam int ROUND_TIMEOUT = 300;   // Cycles allowed for one glyph
   localparam int HOLD_TIMEOUT  = 40;
   localparam int STOP_WINDOW   = 60;

   // Source and dest nibbles per stroke, first stroke in the top byte
   localparam logic [71:0] PAIR_TABLE [16] = '{
      72'h13_36_15_58_34_45_99_99_99,   // A
      72'h21_10_03_36_67_78_99_99_99,   // C
      72'h03_36_01_12_25_58_87_76_99,   // D
      72'h03_36_01_12_34_45_99_99_99,   // F
      72'h01_12_14_47_67_78_99_99_99,   // I
      72'h01_12_14_47_76_63_99_99_99,   // J
      72'h03_36_13_37_99_99_99_99_99,   // K
      72'h03_36_67_78_99_99_99_99_99,   // L
      72'h03_36_07_27_25_58_99_99_99,   // M
      72'h03_36_04_48_85_52_99_99_99,   // N
      72'h21_10_03_36_67_78_85_52_48,   // Q
      72'h03_36_01_12_25_54_43_38_99,   // R
      72'h21_10_03_34_45_58_87_76_99,   // S
      72'h01_12_14_47_99_99_99_99_99,   // T
      72'h03_36_61_18_85_52_99_99_99,   // W
      72'h04_48_24_46_99_99_99_99_99    // X
   };
   localparam logic [63:0]  STROKE_COUNTS = 64'h6686_6644_6698_8464;
   localparam logic [127:0] LETTERS       = "ACDFIJKLMNQRSTWX";

   logic    clock;
   logic    reset;
   round_t  current_round;
   logic    stroke_request;
   square_t source_square;
   square_t dest_square;
   logic    stroke_valid;
   glyph_t  glyph_index;
   letter_t letter;
   logic    round_done;
   logic    first_part_done;

   logic [31:0] rand_state = 32'h58d5;
   glyph_t      model_lfsr;
   logic [7:0]  expected_pairs [$];
   int          request_gap = 0;
   int          check_count = 0;
   int          error_count = 0;
   int          test_count = 0;
   int          test_errors_start = 0;

   character_generator dut (
      .clock           (clock),
      .reset           (reset),
      .current_round   (current_round),
      .stroke_request  (stroke_request),
      .source_square   (source_square),
      .dest_square     (dest_square),
      .stroke_valid    (stroke_valid),
      .glyph_index     (glyph_index),
      .letter          (letter),
      .round_done      (round_done),
      .first_part_done (first_part_done)
   );

   initial begin
      clock = 1'b0;
      forever #20 clock = ~clock;
   end

   ////////////////////
   // Reference model
   ////////////////////

   function automatic logic [31:0] galois_step(input logic [31:0] state);
      if (state[0])
         return (state >> 1) ^ 32'hA300_0000;
      else
         return state >> 1;
   endfunction

   function automatic logic [31:0] take_bits(input int count);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < count; i++) begin
         rand_state = galois_step(rand_state);
         bits       = {bits[30:0], rand_state[0]};
      end
      return bits;
   endfunction

   // XNOR of bits 3 and 2 shifted in at bit 0
   function automatic glyph_t picker_step(input glyph_t state);
      return {state[2:0], ~(state[3] ^ state[2])};
   endfunction

   function automatic int stroke_total_of(input glyph_t g);
      return int'(STROKE_COUNTS[63 - 4 * int'(g) -: 4]);
   endfunction

   function automatic logic [7:0] pair_of(input glyph_t g, input int i);
      return PAIR_TABLE[g][71 - 8 * i -: 8];
   endfunction

   function automatic letter_t letter_of(input glyph_t g);
      return LETTERS[127 - 8 * int'(g) -: 8];
   endfunction

   ////////////////////
   // Checks
   ////////////////////

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      check_count++;
      if (actual !== expected) begin
         $display("ERR %0t: %s is %0h, expected %0h", $time, what, actual, expected);
         error_count++;
      end
   endtask

   task automatic note_failure(input string what);
      $display("At %0t: %s", $time, what);
      error_count++;
   endtask

   task automatic finish_test(input string name);
      test_count++;
      $display("Test %0d, %s: %0d errors", test_count, name, error_count - test_errors_start);
      test_errors_start = error_count;
   endtask

   task automatic drive_request();
      if (request_gap == 0) begin
         stroke_request = 1'b1;
         request_gap    = int'(take_bits(2));   // 0 to 3 idle cycles next
      end else begin
         stroke_request = 1'b0;
         request_gap    = request_gap - 1;
      end
   endtask

   // Mode 1 stops play after the first stroke, mode 2 returns right there
   task automatic play_round(input int mode);
      glyph_t     g;
      logic [7:0] pair;
      int         served;
      int         cycles;
      int         since_valid;
      int         hold;
      model_lfsr = picker_step(model_lfsr);
      g          = model_lfsr;
      expected_pairs.delete();
      for (int i = 0; i < stroke_total_of(g); i++)
         expected_pairs.push_back(pair_of(g, i));
      served      = 0;
      cycles      = 0;
      since_valid = 0;

      while (!round_done) begin
         if (stroke_valid) begin
            if (expected_pairs.size() == 0) begin
               note_failure("A stroke was served after the glyph's last stroke");
            end else begin
               pair = expected_pairs.pop_front();
               check_value(32'(source_square), 32'(pair[7:4]), "source_square");
               check_value(32'(dest_square), 32'(pair[3:0]), "dest_square");
            end
            if (served == 0) begin
               check_value(32'(glyph_index), 32'(g), "glyph_index");
               check_value(32'(letter), 32'(letter_of(g)), "letter");
               if (mode == 1) begin
                  current_round = MAX_ROUND;
               end else if (mode == 2) begin
                  stroke_request = 1'b0;
                  return;
               end
            end
            served++;
            since_valid = 0;
         end
         drive_request();
         @(negedge clock);
         since_valid++;
         cycles++;
         if (cycles > ROUND_TIMEOUT) begin
            note_failure("Timed out waiting for round_done");
            return;
         end
      end

      check_value(32'(served), 32'(stroke_total_of(g)), "strokes served");
      check_value(32'(since_valid), 32'd1, "cycles from last stroke to round_done");

      hold = 0;
      while (round_done) begin
         if (stroke_valid)
            note_failure("A stroke was served while round_done was high");
         drive_request();
         @(negedge clock);
         hold++;
         if (hold > HOLD_TIMEOUT) begin
            note_failure("round_done never fell after the hold time");
            return;
         end
      end
      check_value(32'(hold), 32'(HOLD_CYCLES), "round_done length");
      check_value(32'(source_square), 32'(IDLE_SQUARE), "source_square after round");
      check_value(32'(dest_square), 32'(IDLE_SQUARE), "dest_square after round");
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin
      reset          = 1'b1;
      stroke_request = 1'b0;
      current_round  = '0;
      model_lfsr     = LFSR_SEED;
      repeat (8) @(negedge clock);
      reset = 1'b0;

      @(negedge clock);
      check_value(32'(source_square), 32'(IDLE_SQUARE), "source_square after reset");
      check_value(32'(dest_square), 32'(IDLE_SQUARE), "dest_square after reset");
      check_value(32'(stroke_valid), 32'd0, "stroke_valid after reset");
      check_value(32'(round_done), 32'd0, "round_done after reset");
      check_value(32'(first_part_done), 32'd0, "first_part_done after reset");
      finish_test("reset values");

      for (int r = 0; r < 20; r++) begin
         current_round = 3'(take_bits(3) % 6);
         play_round(0);
      end
      finish_test("twenty rounds of strokes and hold");

      // Last round reached while a glyph is out
      current_round = 3'(take_bits(3) % 6);
      play_round(1);
      for (int c = 0; c < STOP_WINDOW; c++) begin
         check_value(32'(first_part_done), 32'd1, "first_part_done at last round");
         check_value(32'(round_done), 32'd0, "round_done while stopped");
         if (stroke_valid)
            note_failure("A stroke was served after the last round");
         drive_request();
         @(negedge clock);
      end
      current_round = 3'(take_bits(3) % 6);
      @(negedge clock);
      check_value(32'(first_part_done), 32'd0, "first_part_done after resume");
      play_round(0);
      finish_test("stop at the last round");

      play_round(2);
      reset = 1'b1;
      @(negedge clock);
      check_value(32'(source_square), 32'(IDLE_SQUARE), "source_square in reset");
      check_value(32'(dest_square), 32'(IDLE_SQUARE), "dest_square in reset");
      check_value(32'(stroke_valid), 32'd0, "stroke_valid in reset");
      check_value(32'(round_done), 32'd0, "round_done in reset");
      check_value(32'(first_part_done), 32'd0, "first_part_done in reset");
      check_value(32'(glyph_index), 32'd0, "glyph_index in reset");
      @(negedge clock);
      reset      = 1'b0;
      model_lfsr = LFSR_SEED;   // Sequence starts over
      play_round(0);
      play_round(0);
      finish_test("reset in the middle of a glyph");

      $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
      if (error_count == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule
